// ==== build.f ====
logic/nora_pkg.sv
logic/slave_bus_if.sv
logic/spireg_if.sv
logic/sysregs.sv
logic/spi_master.sv
logic/nora_sysctl_top.sv
tb/tb_sysctl.sv

// ==== logic/nora_pkg.sv ====
// shared definitions for the system control block
//   register window offsets
//   SPI control byte views and their union
//   reset defaults passed down as module parameters
package nora_pkg;

    // 5-bit offsets inside the 32-byte window at CPU 0x9F40
    localparam logic [4:0] REG_RAMBANK_MASK = 5'h10;    // CPU 0x9F50
    localparam logic [4:0] REG_SPI_CTRL     = 5'h12;    // CPU 0x9F52
    localparam logic [4:0] REG_SPI_DATA     = 5'h13;    // CPU 0x9F53

    // control byte as written by the CPU
    typedef struct packed {
        logic [3:0] ignored;                            // bits 7..4, don't care
        logic [2:0] clk_div;                            // half SCK period = clk_div+1
        logic       cs_assert;                          // 1 drives CS# low
    } spi_ctrl_wr_t;

    // control byte as read back by the CPU
    typedef struct packed {
        logic       busy;                               // transfer in progress
        logic [2:0] zero;                               // read as 0
        logic [2:0] clk_div;                            // current divider
        logic       cs_assert;                          // current chip select
    } spi_ctrl_rd_t;

    // one byte, command on write and status on read
    typedef union packed {
        spi_ctrl_wr_t wr;
        spi_ctrl_rd_t rd;
    } spi_ctrl_u;

    // reset defaults
    localparam logic [7:0] RAMBANK_MASK_RESET_DEF = 8'h7F;  // only 128 RAM banks after reset
    localparam logic [2:0] SPI_DIV_RESET_DEF      = 3'd3;   // slow SCK until software speeds up

endpackage

// ==== logic/nora_sysctl_top.sv ====
// system control block top level
//   plain CPU slave and SPI pins on the outside
//   register window decoder and SPI master inside
`timescale 1ns/100ps

module nora_sysctl_top
    import nora_pkg::*;
#(
    parameter logic [7:0] RAMBANK_MASK_RESET = RAMBANK_MASK_RESET_DEF,
    parameter logic [2:0] SPI_DIV_RESET      = SPI_DIV_RESET_DEF
)
(
    input  logic        clk,
    input  logic        resetn,             // sync, active low
    // CPU slave port
    input  logic [4:0]  slv_addr_i,
    input  logic [7:0]  slv_datawr_i,
    input  logic        slv_datawr_valid_i,
    input  logic        slv_req_i,
    input  logic        slv_rwn_i,          // 1 read, 0 write
    output logic [7:0]  slv_datard_o,
    // memory mapper
    output logic [7:0]  rambank_mask_o,
    // boot flash
    output logic        spi_sck_o,
    output logic        spi_mosi_o,
    output logic        spi_cs_n_o,
    input  logic        spi_miso_i
);

    slave_bus_if bus_if ();
    spireg_if    spi_if ();

    assign bus_if.addr         = slv_addr_i;
    assign bus_if.datawr       = slv_datawr_i;
    assign bus_if.datawr_valid = slv_datawr_valid_i;
    assign bus_if.req          = slv_req_i;
    assign bus_if.rwn          = slv_rwn_i;
    assign slv_datard_o        = bus_if.datard;

    sysregs #(
        .RAMBANK_MASK_RESET (RAMBANK_MASK_RESET)
    ) u_sysregs (
        .clk            (clk),
        .resetn         (resetn),
        .bus            (bus_if.regs),
        .spi            (spi_if.host),
        .rambank_mask_o (rambank_mask_o)
    );

    spi_master #(
        .DIV_RESET (SPI_DIV_RESET)
    ) u_spi_master (
        .clk        (clk),
        .resetn     (resetn),
        .regs       (spi_if.core),
        .spi_sck_o  (spi_sck_o),
        .spi_mosi_o (spi_mosi_o),
        .spi_cs_n_o (spi_cs_n_o),
        .spi_miso_i (spi_miso_i)
    );

endmodule

// ==== logic/slave_bus_if.sv ====
// CPU slave port bundle
//   bus side drives address, write data and strobes
//   register side returns read data
`timescale 1ns/100ps

interface slave_bus_if;
    logic [4:0] addr;           // window offset
    logic [7:0] datawr;         // write data, valid late in the cycle
    logic       datawr_valid;   // qualifies datawr
    logic [7:0] datard;         // combinational read data
    logic       req;            // chip select for the window
    logic       rwn;            // 1 read, 0 write

    modport bus (
        output addr,
        output datawr,
        output datawr_valid,
        input  datard,
        output req,
        output rwn
    );

    modport regs (
        input  addr,
        input  datawr,
        input  datawr_valid,
        output datard,
        input  req,
        input  rwn
    );
endinterface

// ==== logic/spi_master.sv ====
// SPI master for the boot flash, mode 0, MSB first
//   control register written through the command view of the union
//   status and receive byte returned on read
//   SCK divider and 8-bit shift engine
`timescale 1ns/100ps

module spi_master
    import nora_pkg::*;
#(
    parameter logic [2:0] DIV_RESET = SPI_DIV_RESET_DEF
)
(
    input  logic        clk,
    input  logic        resetn,         // sync, active low
    spireg_if.core      regs,           // from the window decoder
    output logic        spi_sck_o,
    output logic        spi_mosi_o,
    output logic        spi_cs_n_o,
    input  logic        spi_miso_i
);

    spi_ctrl_u  ctrl_wr;                // incoming command byte
    spi_ctrl_u  ctrl_rd;                // outgoing status byte
    logic       cs_n_r;                 // registered inverse of cs_assert
    logic [2:0] clk_div_r;
    logic       busy_r;
    logic       sck_r;
    logic [2:0] div_cnt;                // clk cycles within a half period
    logic [2:0] bit_cnt;                // falling edges done
    logic [7:0] shift_r;                // tx out of bit 7, rx into bit 0
    logic [7:0] rx_r;                   // last received byte
    logic       miso_q;                 // sampled on SCK rise
    logic       half_tick;              // end of a half period
    logic       ctrl_wr_en;
    logic       data_wr_en;

    assign ctrl_wr    = regs.d_wr;
    assign ctrl_wr_en = regs.wr && !regs.ad;
    assign data_wr_en = regs.wr && regs.ad && !busy_r;  // ignored while busy
    assign half_tick  = busy_r && (div_cnt == clk_div_r);

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            cs_n_r    <= 1'b1;          // flash deselected
            clk_div_r <= DIV_RESET;
            busy_r    <= 1'b0;
            sck_r     <= 1'b0;          // mode 0 idles low
            div_cnt   <= 3'd0;
            bit_cnt   <= 3'd0;
            shift_r   <= 8'h00;         // MOSI low at reset
        end
        else
        begin
            if (ctrl_wr_en)
            begin
                cs_n_r <= !ctrl_wr.wr.cs_assert;
                if (!busy_r)
                begin
                    clk_div_r <= ctrl_wr.wr.clk_div;    // held during a transfer
                end
            end

            if (data_wr_en)
            begin
                shift_r <= regs.d_wr;   // bit 7 on MOSI next cycle
                busy_r  <= 1'b1;
                sck_r   <= 1'b0;
                div_cnt <= 3'd0;
                bit_cnt <= 3'd0;
            end
            else if (busy_r)
            begin
                if (half_tick)
                begin
                    div_cnt <= 3'd0;
                    sck_r   <= !sck_r;
                    if (sck_r)
                    begin
                        // falling edge, shift in the sampled bit
                        shift_r <= {shift_r[6:0], miso_q};
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                        begin
                            busy_r <= 1'b0; // 16 half periods done
                        end
                    end
                end
                else
                begin
                    div_cnt <= div_cnt + 3'd1;
                end
            end
        end
    end

    // MISO sample and received byte
    always_ff @(posedge clk)
    begin
        if (half_tick && !sck_r)
        begin
            miso_q <= spi_miso_i;       // rising edge sample
        end
        if (half_tick && sck_r && (bit_cnt == 3'd7))
        begin
            rx_r <= {shift_r[6:0], miso_q}; // full byte at the last fall
        end
    end

    // status through the read view
    always_comb
    begin
        ctrl_rd              = '0;      // upper bits read zero
        ctrl_rd.rd.busy      = busy_r;
        ctrl_rd.rd.clk_div   = clk_div_r;
        ctrl_rd.rd.cs_assert = !cs_n_r;
        regs.d_rd            = regs.ad ? rx_r : ctrl_rd;
    end

    assign spi_sck_o  = sck_r;
    assign spi_mosi_o = shift_r[7];
    assign spi_cs_n_o = cs_n_r;

endmodule

// ==== logic/spireg_if.sv ====
// register port between the window decoder and the SPI master
//   host side selects and strobes, core side answers
`timescale 1ns/100ps

interface spireg_if;
    logic [7:0] d_wr;           // write data into the core
    logic [7:0] d_rd;           // read data from CONTROL or DATA
    logic       wr;             // one-cycle write strobe
    logic       rd;             // one-cycle read strobe, spare for receive-clear
    logic       ad;             // 0 CONTROL, 1 DATA

    modport host (
        output d_wr,
        input  d_rd,
        output wr,
        output rd,
        output ad
    );

    modport core (
        input  d_wr,
        output d_rd,
        input  wr,
        input  rd,
        input  ad
    );
endinterface

// ==== logic/sysregs.sv ====
// system register window decoder
//   address decode for RAMBANK_MASK and the SPI master
//   combinational read multiplexer
//   RAMBANK_MASK register
`timescale 1ns/100ps

module sysregs
    import nora_pkg::*;
#(
    parameter logic [7:0] RAMBANK_MASK_RESET = RAMBANK_MASK_RESET_DEF
)
(
    input  logic        clk,
    input  logic        resetn,             // sync, active low
    slave_bus_if.regs   bus,                // CPU slave port
    spireg_if.host      spi,                // to the SPI master
    output logic [7:0]  rambank_mask_o      // to the memory mapper
);

    logic       mask_cs;                    // RAMBANK_MASK selected
    logic       spi_cs;                     // CONTROL or DATA selected
    logic       wr_qual;                    // write cycle with valid data
    logic       rd_qual;                    // read cycle strobe
    logic [7:0] rambank_mask_r;

    // decode and read mux, all combinational
    always_comb
    begin
        mask_cs    = 1'b0;
        spi_cs     = 1'b0;
        bus.datard = 8'h00;                 // unmapped reads as zero
        if (bus.req)
        begin
            case (bus.addr)
                REG_RAMBANK_MASK:
                begin
                    mask_cs    = 1'b1;
                    bus.datard = rambank_mask_r;
                end
                REG_SPI_CTRL, REG_SPI_DATA:
                begin
                    spi_cs     = 1'b1;
                    bus.datard = spi.d_rd;  // status or received byte
                end
                default:
                begin
                    bus.datard = 8'h00;
                end
            endcase
        end
    end

    assign wr_qual = !bus.rwn && bus.datawr_valid;
    assign rd_qual = bus.rwn && bus.datawr_valid;   // same strobe timing as writes

    // forward to the SPI master
    assign spi.d_wr = bus.datawr;
    assign spi.wr   = spi_cs && wr_qual;
    assign spi.rd   = spi_cs && rd_qual;
    assign spi.ad   = bus.addr[0];                  // 0x12 CONTROL, 0x13 DATA

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            rambank_mask_r <= RAMBANK_MASK_RESET;
        end
        else if (mask_cs && wr_qual)
        begin
            rambank_mask_r <= bus.datawr;           // takes effect at this edge
        end
    end

    assign rambank_mask_o = rambank_mask_r;

endmodule

// ==== tb/tb_sysctl.sv ====
// testbench for the system control block
//   clock, reset and CPU bus tasks
//   MOSI to MISO loopback on the flash pins
//   register, transfer length and SCK idle assertions
//   cycle counter timeout
`timescale 1ns/100ps

module tb_sysctl
    import nora_pkg::*;
();

    localparam int HALF_PERIOD    = 20;             // 40 ns clock
    localparam int TIMEOUT_CYCLES = 3000;           // 8 xfers of <= 128 cycles plus bus traffic

    logic       clk;
    logic       resetn;
    logic [4:0] slv_addr;
    logic [7:0] slv_datawr;
    logic       slv_datawr_valid;
    logic       slv_req;
    logic       slv_rwn;
    logic [7:0] slv_datard;
    logic [7:0] rambank_mask;
    logic       spi_sck;
    logic       spi_mosi;
    logic       spi_cs_n;
    wire        spi_miso;
    int         cycle_cnt = 0;
    int         sck_rises = 0;
    integer     seed;

    assign spi_miso = spi_mosi;                     // loopback, rx must equal tx

    nora_sysctl_top UUT (
        .clk                (clk),
        .resetn             (resetn),
        .slv_addr_i         (slv_addr),
        .slv_datawr_i       (slv_datawr),
        .slv_datawr_valid_i (slv_datawr_valid),
        .slv_req_i          (slv_req),
        .slv_rwn_i          (slv_rwn),
        .slv_datard_o       (slv_datard),
        .rambank_mask_o     (rambank_mask),
        .spi_sck_o          (spi_sck),
        .spi_mosi_o         (spi_mosi),
        .spi_cs_n_o         (spi_cs_n),
        .spi_miso_i         (spi_miso)
    );

    always #HALF_PERIOD clk = !clk;

    always @(posedge spi_sck)
    begin
        sck_rises <= sck_rises + 1;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout, tests did not finish within %0d clk cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // SCK must idle low while a CONTROL read shows busy clear
    sck_idle_a: assert property (@(posedge clk) disable iff (!resetn)
        (slv_req && slv_rwn && (slv_addr == REG_SPI_CTRL) && !slv_datard[7]) |-> !spi_sck)
    else
    begin
        $display("spi_sck_o is high while CONTROL reads busy as 0");
        abort_run();
    end

    task automatic abort_run();
        begin
            $display("*** FAILED ***");
            $fatal(1, "run stopped at cycle %0d", cycle_cnt);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        begin
            assert (act === exp)
            else
            begin
                $display("[ERROR] %s: expected 0x%0h actual 0x%0h", name, exp, act);
                abort_run();
            end
        end
    endtask

    // command byte through the write view
    function automatic logic [7:0] ctrl_byte(input logic cs, input logic [2:0] div);
        spi_ctrl_u c;
        begin
            c              = '0;
            c.wr.cs_assert = cs;
            c.wr.clk_div   = div;
            return c;
        end
    endfunction

    // expected status through the read view
    function automatic logic [7:0] status_byte(input logic busy, input logic [2:0] div,
                                               input logic cs);
        spi_ctrl_u c;
        begin
            c              = '0;                    // bits 6..4 read zero
            c.rd.busy      = busy;
            c.rd.clk_div   = div;
            c.rd.cs_assert = cs;
            return c;
        end
    endfunction

    // one write cycle, req and valid high for a single clk
    task automatic bus_write(input logic [4:0] addr, input logic [7:0] data);
        begin
            @(negedge clk);
            slv_addr         = addr;
            slv_datawr       = data;
            slv_rwn          = 1'b0;
            slv_req          = 1'b1;
            slv_datawr_valid = 1'b1;
            @(negedge clk);                         // write edge has passed
            slv_req          = 1'b0;
            slv_datawr_valid = 1'b0;
            slv_rwn          = 1'b1;
        end
    endtask

    // read is combinational, sampled mid low phase
    task automatic bus_read(input logic [4:0] addr, output logic [7:0] data);
        begin
            @(negedge clk);
            slv_addr = addr;
            slv_rwn  = 1'b1;
            slv_req  = 1'b1;
            #(HALF_PERIOD / 2);
            data     = slv_datard;
        end
    endtask

    // poll CONTROL until busy clears, returns the cycle of the fall
    task automatic wait_idle(output int t_end);
        logic [7:0] st;
        begin
            st = 8'h80;
            while (st[7])
            begin
                bus_read(REG_SPI_CTRL, st);
            end
            t_end = cycle_cnt;
        end
    endtask

    task automatic loopback(input string name, input logic [7:0] data, input logic [2:0] div);
        int         t_start;
        int         t_end;
        int         rises;
        logic [7:0] rd;
        begin
            rises = sck_rises;
            bus_write(REG_SPI_DATA, data);
            t_start = cycle_cnt;                    // counts the write edge
            wait_idle(t_end);
            check_value({name, " length"}, 16 * (div + 1), t_end - t_start);
            check_value({name, " sck rises"}, 8, sck_rises - rises);
            bus_read(REG_SPI_DATA, rd);
            check_value({name, " rx byte"}, data, rd);
        end
    endtask

    initial
    begin : main
        logic [7:0] rd;
        logic [7:0] data;
        int         rises;
        int         t_start;
        int         t_end;
        seed             = 66;
        clk              = 1'b0;
        resetn           = 1'b0;
        slv_addr         = 5'h00;
        slv_datawr       = 8'h00;
        slv_datawr_valid = 1'b0;
        slv_req          = 1'b0;
        slv_rwn          = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        // reset values, mask 0x7F and divider 3
        check_value("reset mask pin", 8'h7F, rambank_mask);
        bus_read(REG_RAMBANK_MASK, rd);
        check_value("reset mask read", 8'h7F, rd);
        bus_read(REG_SPI_CTRL, rd);
        check_value("reset control", status_byte(1'b0, 3'd3, 1'b0), rd);
        check_value("reset cs_n", 1'b1, spi_cs_n);
        check_value("reset sck", 1'b0, spi_sck);

        // mask register and unmapped offsets
        data = $random(seed);
        bus_write(REG_RAMBANK_MASK, data);
        check_value("mask pin", data, rambank_mask);
        bus_read(REG_RAMBANK_MASK, rd);
        check_value("mask read", data, rd);
        bus_read(5'h00, rd);
        check_value("unmapped 0x00", 8'h00, rd);
        bus_read(5'h11, rd);
        check_value("unmapped 0x11", 8'h00, rd);

        // upper command bits ignored, read back as zero
        bus_write(REG_SPI_CTRL, 8'hF5);
        bus_read(REG_SPI_CTRL, rd);
        check_value("control 0xF5", status_byte(1'b0, 3'd2, 1'b1), rd);
        check_value("cs_n asserted", 1'b0, spi_cs_n);
        bus_write(REG_SPI_CTRL, ctrl_byte(1'b0, 3'd2));
        check_value("cs_n released", 1'b1, spi_cs_n);

        // loopback at fastest and reset divider
        bus_write(REG_SPI_CTRL, ctrl_byte(1'b1, 3'd0));
        for (int k = 0; k < 3; k++)
        begin
            data = $random(seed);
            loopback("loopback div 0", data, 3'd0);
        end
        bus_write(REG_SPI_CTRL, ctrl_byte(1'b1, 3'd3));
        for (int k = 0; k < 4; k++)
        begin
            data = $random(seed);
            loopback("loopback div 3", data, 3'd3);
        end

        // writes while busy, DATA dropped and only cs_assert taken
        bus_write(REG_SPI_CTRL, ctrl_byte(1'b1, 3'd1));
        data  = $random(seed);
        rises = sck_rises;
        bus_write(REG_SPI_DATA, data);
        t_start = cycle_cnt;
        bus_write(REG_SPI_DATA, ~data);
        bus_write(REG_SPI_CTRL, ctrl_byte(1'b0, 3'd7));
        check_value("busy cs_n released", 1'b1, spi_cs_n);
        wait_idle(t_end);
        check_value("busy length", 16 * 2, t_end - t_start);
        check_value("busy sck rises", 8, sck_rises - rises);
        bus_read(REG_SPI_DATA, rd);
        check_value("busy rx byte", data, rd);
        bus_read(REG_SPI_CTRL, rd);
        check_value("busy divider held", status_byte(1'b0, 3'd1, 1'b0), rd);

        $display("*** PASSED ***");
        $finish;
    end

endmodule
